/* dv/l2_cache_trace.txt */
# Columns in hex: op (0 load, 1 store), line address, byte mask, store data, expected line
# Lines are written with word 3 first, word 0 sits at the lowest address
# Each memory word starts as its byte address XOR a5a50000
0 0000010 0000 00000000000000000000000000000000 a5a5010ca5a50108a5a50104a5a50100
0 0000010 0000 00000000000000000000000000000000 a5a5010ca5a50108a5a50104a5a50100
1 0000010 30f1 deadbeefcafef00d123456789abcdef0 a5a5beefa5a5010812345678a5a501f0
0 0000010 0000 00000000000000000000000000000000 a5a5beefa5a5010812345678a5a501f0
0 0000018 0000 00000000000000000000000000000000 a5a5018ca5a50188a5a50184a5a50180
0 0000020 0000 00000000000000000000000000000000 a5a5020ca5a50208a5a50204a5a50200
0 0000010 0000 00000000000000000000000000000000 a5a5beefa5a5010812345678a5a501f0
1 0000021 ffff 76543210fedcba980123456789abcdef 76543210fedcba980123456789abcdef
0 0000021 0000 00000000000000000000000000000000 76543210fedcba980123456789abcdef
0 0000029 0000 00000000000000000000000000000000 a5a5029ca5a50298a5a50294a5a50290
0 0000031 0000 00000000000000000000000000000000 a5a5031ca5a50318a5a50314a5a50310
0 0000021 0000 00000000000000000000000000000000 76543210fedcba980123456789abcdef
1 0000031 000f 000000000000000000000000cafebabe a5a5031ca5a50318a5a50314cafebabe
0 0000020 0000 00000000000000000000000000000000 a5a5020ca5a50208a5a50204a5a50200
0 0000031 0000 00000000000000000000000000000000 a5a5031ca5a50318a5a50314cafebabe
1 0000000 f000 0badf00d000000000000000000000000 0badf00da5a50008a5a50004a5a50000
0 0000010 0000 00000000000000000000000000000000 a5a5beefa5a5010812345678a5a501f0
0 0000000 0000 00000000000000000000000000000000 0badf00da5a50008a5a50004a5a50000
0 0000020 0000 00000000000000000000000000000000 a5a5020ca5a50208a5a50204a5a50200
0 0000008 0000 00000000000000000000000000000000 a5a5008ca5a50088a5a50084a5a50080
0 0000000 0000 00000000000000000000000000000000 0badf00da5a50008a5a50004a5a50000

/* l2_cache.f */
design/l2_cache_pkg.sv
design/l2_tag_array.sv
design/l2_data_array.sv
design/l2_miss_fsm.sv
design/l2_burst_counter.sv
design/l2_cache_top.sv
dv/l2_mem_model.sv
dv/l2_cache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it from the project root, look for the pass line
verilator --binary --timing --assert --top-module l2_cache_tb -f l2_cache.f -o l2_cache_sim &&
./obj_dir/l2_cache_sim | grep "Simulation completed successfully" || { echo "FAIL"; exit 1; }

/* dv/l2_cache_tb.sv */
/* Testbench for the level-2 cache. Replays the request trace under random
   response back-pressure and memory delays, checking responses in order. */
module l2_cache_tb;
	import l2_cache_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 5;
	localparam int ACCEPT_TIMEOUT = 200;
	localparam int RESP_TIMEOUT = 400;
	localparam logic [31:0] LFSR_SEED = 32'd65890;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;
	// The trace has thirteen misses and three of them evict a dirty line
	localparam int EXP_READ_BEATS = 52;
	localparam int EXP_WRITE_BEATS = 12;

	typedef struct packed
	{
		cache_req_t req;
		line_u expect_line;
	} trace_item_t;

	logic clk;
	logic rst;
	logic req_valid;
	logic req_ready;
	cache_req_t req;
	logic resp_valid;
	logic resp_ready;
	cache_resp_t resp;
	logic mem_req;
	logic mem_write;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [31:0] mem_rdata;
	logic mem_ack;
	logic mem_grant;
	int mem_reads;
	int mem_writes;
	logic [31:0] lfsr_q;
	trace_item_t trace_q[$];

	l2_cache_top dut_i (
		.clk(clk),
		.rst_i(rst),
		.req_valid_i(req_valid),
		.req_ready_o(req_ready),
		.req_i(req),
		.resp_valid_o(resp_valid),
		.resp_ready_i(resp_ready),
		.resp_o(resp),
		.mem_req_o(mem_req),
		.mem_write_o(mem_write),
		.mem_addr_o(mem_addr),
		.mem_wdata_o(mem_wdata),
		.mem_ack_i(mem_ack),
		.mem_rdata_i(mem_rdata)
	);

	l2_mem_model mem_i (
		.clk(clk),
		.rst_i(rst),
		.req_i(mem_req),
		.write_i(mem_write),
		.addr_i(mem_addr),
		.wdata_i(mem_wdata),
		.grant_i(mem_grant),
		.ack_o(mem_ack),
		.rdata_o(mem_rdata),
		.read_beats_o(mem_reads),
		.write_beats_o(mem_writes)
	);

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ LFSR_TAPS) : (state >> 1);
	endfunction

	task automatic stop_on_failure();
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout while waiting for %s", what);
		stop_on_failure();
	endtask

	task automatic load_trace();
		int fd;
		int fields;
		string text;
		trace_item_t item;
		logic [3:0] op_field;
		logic [27:0] addr_field;
		logic [15:0] mask_field;
		logic [127:0] data_field;
		logic [127:0] expect_field;
		fd = $fopen("dv/l2_cache_trace.txt", "r");
		assert (fd != 0)
		else
		begin
			$display("cannot open the request trace file");
			stop_on_failure();
		end
		while (!$feof(fd))
		begin
			text = "";
			fields = $fgets(text, fd);
			// Skip comments and blank lines
			if (text.len() < 2 || text[0] == "#")
				continue;
			fields = $sscanf(text, "%h %h %h %h %h", op_field, addr_field, mask_field,
				data_field, expect_field);
			assert (fields == 5)
			else
			begin
				$display("malformed trace line: %s", text);
				stop_on_failure();
			end
			item.req.op = op_e'(op_field[0]);
			item.req.line_addr = addr_field;
			item.req.mask = mask_field;
			item.req.data.flat = data_field;
			item.expect_line.flat = expect_field;
			trace_q.push_back(item);
		end
		$fclose(fd);
		assert (trace_q.size() > 0)
		else
		begin
			$display("the request trace holds no requests");
			stop_on_failure();
		end
	endtask

	// Handshakes are judged at the falling edge, where inputs and outputs are settled
	task automatic drive_requests();
		int waited;
		logic accepted;
		for (int k = 0; k < trace_q.size(); k++)
		begin
			req_valid = 1'b1;
			req = trace_q[k].req;
			waited = 0;
			do
			begin
				@(negedge clk);
				accepted = req_ready;
				waited++;
				if (!accepted && waited > ACCEPT_TIMEOUT)
					stop_on_timeout("request acceptance");
			end
			while (!accepted);
			@(posedge clk);
			#1;
		end
		req_valid = 1'b0;
		req = '0;
	endtask

	task automatic collect_responses();
		int waited;
		logic taken;
		for (int k = 0; k < trace_q.size(); k++)
		begin
			waited = 0;
			do
			begin
				@(negedge clk);
				taken = resp_valid && resp_ready;
				waited++;
				if (!taken && waited > RESP_TIMEOUT)
					stop_on_timeout("a response");
			end
			while (!taken);
			assert (resp.op == trace_q[k].req.op)
			else
			begin
				$display("error: resp_o.op expected %h got %h (response %0d)",
					trace_q[k].req.op, resp.op, k);
				stop_on_failure();
			end
			assert (resp.data == trace_q[k].expect_line)
			else
			begin
				$display("error: resp_o.data expected %h got %h (response %0d)",
					trace_q[k].expect_line, resp.data, k);
				stop_on_failure();
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Clock, random back-pressure and main sequence
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// The response and memory sides share one LFSR with one step per random bit
	initial
	begin
		lfsr_q = LFSR_SEED;
		resp_ready = 1'b0;
		mem_grant = 1'b0;
		forever
		begin
			@(posedge clk);
			#1;
			lfsr_q = lfsr_next(lfsr_q);
			resp_ready = lfsr_q[0];
			lfsr_q = lfsr_next(lfsr_q);
			mem_grant = lfsr_q[0];
		end
	end

	always @(negedge clk)
	begin
		if (mem_req)
			assert (mem_addr[31:12] == '0)
			else
			begin
				$display("error: mem_addr_o %h is outside the modeled memory", mem_addr);
				stop_on_failure();
			end
	end

	initial
	begin
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		load_trace();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		@(negedge clk);
		assert (!resp_valid && !mem_req && !mem_write && req_ready)
		else
		begin
			$display("error: after reset resp_valid_o %h mem_req_o %h mem_write_o %h req_ready_o %h",
				resp_valid, mem_req, mem_write, req_ready);
			stop_on_failure();
		end
		@(posedge clk);
		#1;

		fork
			drive_requests();
			collect_responses();
		join

		// Hits must not touch memory, so the totals pin down every burst
		assert (mem_reads == EXP_READ_BEATS)
		else
		begin
			$display("error: read_beats_o expected %h got %h", EXP_READ_BEATS, mem_reads);
			stop_on_failure();
		end
		assert (mem_writes == EXP_WRITE_BEATS)
		else
		begin
			$display("error: write_beats_o expected %h got %h", EXP_WRITE_BEATS, mem_writes);
			stop_on_failure();
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* dv/l2_mem_model.sv */
/* Word memory behind the cache's beat bus. Every word starts as its byte
   address XOR 0xA5A50000, and write beats update the array. */
module l2_mem_model (
	input logic clk,
	input logic rst_i,
	input logic req_i,
	input logic write_i,
	input logic [31:0] addr_i,
	input logic [31:0] wdata_i,
	input logic grant_i,
	output logic ack_o,
	output logic [31:0] rdata_o,
	output int read_beats_o,
	output int write_beats_o
);
	// 4 KB of modeled space, word addressed
	localparam int DEPTH = 1024;

	logic [31:0] words_q [DEPTH];
	logic [9:0] index;

	assign index = addr_i[11:2];

	// A low grant bit holds the beat for another cycle
	assign ack_o = req_i && grant_i;
	assign rdata_o = words_q[index];

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			for (int i = 0; i < DEPTH; i++)
				words_q[i] <= 32'(i * 4) ^ 32'hA5A50000;
			read_beats_o <= 0;
			write_beats_o <= 0;
		end
		else if (ack_o)
		begin
			if (write_i)
			begin
				words_q[index] <= wdata_i;
				write_beats_o <= write_beats_o + 1;
			end
			else
				read_beats_o <= read_beats_o + 1;
		end
	end

endmodule

/* design/l2_cache_top.sv */
/* Level-2 cache top: three-stage request pipeline around the tag and data
   arrays, with a single-miss engine on a beat-by-beat memory bus. */
module l2_cache_top (
	input logic clk,
	input logic rst_i,
	input logic req_valid_i,
	output logic req_ready_o,
	input l2_cache_pkg::cache_req_t req_i,
	output logic resp_valid_o,
	input logic resp_ready_i,
	output l2_cache_pkg::cache_resp_t resp_o,
	output logic mem_req_o,
	output logic mem_write_o,
	output logic [31:0] mem_addr_o,
	output logic [31:0] mem_wdata_o,
	input logic mem_ack_i,
	input logic [31:0] mem_rdata_i
);
	import l2_cache_pkg::*;

	logic s1_valid;
	logic s2_valid;
	cache_req_t s1_req;
	cache_req_t s2_req;
	logic s1_free;
	logic s2_free;
	logic s3_free;
	logic s2_advance;
	logic s2_store;
	logic [SET_BITS-1:0] s2_set;
	logic [LINE_BYTES-1:0] merge_mask;
	lookup_t lookup;
	line_u s2_line;
	line_u fill_line;
	logic miss_start;
	logic fill;
	logic miss_done;
	logic beat_done;
	logic last_beat;
	logic [BEAT_BITS-1:0] beat;
	logic [LINE_ADDR_BITS-1:0] mem_line_addr;

	////////////////////////////////////////////////////////////////////////////
	// Stall chain, back to front
	////////////////////////////////////////////////////////////////////////////

	assign s3_free = !resp_valid_o || resp_ready_i;
	assign s2_advance = s2_valid && lookup.hit && s3_free;
	assign s2_free = !s2_valid || s2_advance;
	assign s1_free = !s1_valid || s2_free;
	assign req_ready_o = s1_free;

	assign s2_store = (s2_req.op == OP_STORE);
	assign s2_set = s2_req.line_addr[SET_BITS-1:0];

	// Store bytes only merge on a hit, so a miss reads the plain victim
	assign merge_mask = (s2_valid && lookup.hit && s2_store) ? s2_req.mask : '0;
	assign miss_start = s2_valid && !lookup.hit;
	assign beat_done = mem_req_o && mem_ack_i;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			resp_valid_o <= 1'b0;
		end
		else
		begin
			if (s1_free)
				s1_valid <= req_valid_i;
			if (s2_free)
				s2_valid <= s1_valid;
			if (s3_free)
				resp_valid_o <= s2_advance;
		end
	end

	always_ff @(posedge clk)
	begin
		if (s1_free && req_valid_i)
			s1_req <= req_i;
		if (s2_free && s1_valid)
			s2_req <= s1_req;
		if (s2_advance)
		begin
			resp_o.op <= s2_req.op;
			resp_o.data <= s2_line;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Arrays and miss engine
	////////////////////////////////////////////////////////////////////////////

	l2_tag_array tag_i (
		.clk(clk),
		.rst_i(rst_i),
		.line_addr_i(s2_req.line_addr),
		.access_i(s2_advance),
		.store_i(s2_advance && s2_store),
		.fill_i(fill),
		.lookup_o(lookup)
	);

	l2_data_array data_i (
		.clk(clk),
		.rst_i(rst_i),
		.set_i(s2_set),
		.way_i(lookup.way),
		.mask_i(merge_mask),
		.store_data_i(s2_req.data),
		.write_i(s2_advance && s2_store),
		.fill_i(fill),
		.fill_data_i(fill_line),
		.line_o(s2_line)
	);

	l2_miss_fsm miss_i (
		.clk(clk),
		.rst_i(rst_i),
		.miss_start_i(miss_start),
		.victim_dirty_i(lookup.victim_dirty),
		.beat_done_i(beat_done),
		.last_beat_i(last_beat),
		.mem_req_o(mem_req_o),
		.mem_write_o(mem_write_o),
		.fill_o(fill),
		.miss_done_o(miss_done)
	);

	l2_burst_counter burst_i (
		.clk(clk),
		.rst_i(rst_i),
		.active_i(mem_req_o),
		.beat_done_i(beat_done),
		.victim_line_i(s2_line),
		.rdata_i(mem_rdata_i),
		.beat_o(beat),
		.last_beat_o(last_beat),
		.wdata_o(mem_wdata_o),
		.fill_line_o(fill_line)
	);

	// Write-back goes to the victim's own address
	assign mem_line_addr = mem_write_o ? {lookup.victim_tag, s2_set} : s2_req.line_addr;
	assign mem_addr_o = {mem_line_addr, beat, 2'b00};

	a_resp_stable: assert property (@(posedge clk) disable iff (rst_i)
		resp_valid_o && !resp_ready_i |=> resp_valid_o && $stable(resp_o))
		else $error("response changed while stalled");

	// The held request must hit right after the refill lands
	a_retry_hits: assert property (@(posedge clk) disable iff (rst_i)
		miss_done |-> s2_valid && lookup.hit)
		else $error("request still misses after refill");

endmodule

/* design/l2_burst_counter.sv */
/* Beat counter for memory bursts. Picks the victim word to write back
   and collects read words into the fill line. */
module l2_burst_counter (
	input logic clk,
	input logic rst_i,
	input logic active_i,
	input logic beat_done_i,
	input l2_cache_pkg::line_u victim_line_i,
	input logic [l2_cache_pkg::WORD_BITS-1:0] rdata_i,
	output logic [l2_cache_pkg::BEAT_BITS-1:0] beat_o,
	output logic last_beat_o,
	output logic [l2_cache_pkg::WORD_BITS-1:0] wdata_o,
	output l2_cache_pkg::line_u fill_line_o
);
	import l2_cache_pkg::*;

	logic [BEAT_BITS-1:0] beat_q;
	line_u fill_q;

	// Burst length equals 2**BEAT_BITS so the count wraps on its own
	always_ff @(posedge clk)
	begin
		if (rst_i || !active_i)
			beat_q <= '0;
		else if (beat_done_i)
			beat_q <= beat_q + 1'b1;
	end

	// Write-back beats land here too but the read burst overwrites them
	always_ff @(posedge clk)
	begin
		if (active_i && beat_done_i)
			fill_q.words[beat_q] <= rdata_i;
	end

	assign beat_o = beat_q;
	assign last_beat_o = (beat_q == BEAT_BITS'(LINE_WORDS - 1));
	assign wdata_o = victim_line_i.words[beat_q];
	assign fill_line_o = fill_q;

endmodule

/* design/l2_miss_fsm.sv */
/* Miss sequencer: optional dirty victim write-back, line read, then one
   refill cycle. Handles one miss at a time. */
module l2_miss_fsm (
	input logic clk,
	input logic rst_i,
	input logic miss_start_i,
	input logic victim_dirty_i,
	input logic beat_done_i,
	input logic last_beat_i,
	output logic mem_req_o,
	output logic mem_write_o,
	output logic fill_o,
	output logic miss_done_o
);
	typedef enum logic [1:0]
	{
		ST_IDLE,
		ST_WRITEBACK,
		ST_READ,
		ST_REFILL
	} state_e;

	state_e state_q;
	state_e state_d;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:
			begin
				if (miss_start_i)
					state_d = victim_dirty_i ? ST_WRITEBACK : ST_READ;
			end

			ST_WRITEBACK:
			begin
				if (beat_done_i && last_beat_i)
					state_d = ST_READ;
			end

			ST_READ:
			begin
				if (beat_done_i && last_beat_i)
					state_d = ST_REFILL;
			end

			default:
				state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state_q <= ST_IDLE;
			miss_done_o <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			// Pulses in the cycle the held request retries
			miss_done_o <= (state_q == ST_REFILL);
		end
	end

	assign mem_req_o = (state_q == ST_WRITEBACK) || (state_q == ST_READ);
	assign mem_write_o = (state_q == ST_WRITEBACK);
	assign fill_o = (state_q == ST_REFILL);

	a_bus_quiet: assert property (@(posedge clk) disable iff (rst_i)
		(state_q == ST_IDLE || state_q == ST_REFILL) |-> !mem_req_o)
		else $error("memory request outside a burst");

endmodule

/* design/l2_data_array.sv */
/* Line storage for all sets and ways. Reads the addressed line with any
   store bytes merged in and writes either that merge or a refill line. */
module l2_data_array (
	input logic clk,
	input logic rst_i,
	input logic [l2_cache_pkg::SET_BITS-1:0] set_i,
	input logic way_i,
	input logic [l2_cache_pkg::LINE_BYTES-1:0] mask_i,
	input l2_cache_pkg::line_u store_data_i,
	input logic write_i,
	input logic fill_i,
	input l2_cache_pkg::line_u fill_data_i,
	output l2_cache_pkg::line_u line_o
);
	import l2_cache_pkg::*;

	line_u lines_q [NUM_SETS*NUM_WAYS];

	logic [SET_BITS:0] idx;
	line_u old_line;

	assign idx = {way_i, set_i};
	assign old_line = lines_q[idx];

	// Byte merge, a zero mask passes the stored line through
	always_comb
	begin
		for (int b = 0; b < LINE_BYTES; b++)
			line_o.flat[b*8 +: 8] = mask_i[b] ? store_data_i.flat[b*8 +: 8]
				: old_line.flat[b*8 +: 8];
	end

	always_ff @(posedge clk)
	begin
		if (fill_i)
			lines_q[idx] <= fill_data_i;
		else if (write_i)
			lines_q[idx] <= line_o;
	end

	a_one_writer: assert property (@(posedge clk) disable iff (rst_i)
		!(write_i && fill_i))
		else $error("store and refill in the same cycle");

endmodule

/* design/l2_tag_array.sv */
/* Tag, valid, dirty and LRU state for every set and way.
   Checks the lookup address combinationally and names the hit or victim way. */
module l2_tag_array (
	input logic clk,
	input logic rst_i,
	input logic [l2_cache_pkg::LINE_ADDR_BITS-1:0] line_addr_i,
	input logic access_i,
	input logic store_i,
	input logic fill_i,
	output l2_cache_pkg::lookup_t lookup_o
);
	import l2_cache_pkg::*;

	logic [TAG_BITS-1:0] tag_q [NUM_SETS][NUM_WAYS];
	logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
	logic [NUM_SETS-1:0][NUM_WAYS-1:0] dirty_q;
	// Per set, the way to evict next
	logic [NUM_SETS-1:0] lru_q;

	logic [SET_BITS-1:0] set;
	logic [TAG_BITS-1:0] tag;
	logic [NUM_WAYS-1:0] hit_vec;
	logic hit;
	logic victim;
	logic way;

	assign set = line_addr_i[SET_BITS-1:0];
	assign tag = line_addr_i[LINE_ADDR_BITS-1:SET_BITS];

	always_comb
	begin
		for (int w = 0; w < NUM_WAYS; w++)
			hit_vec[w] = valid_q[set][w] && (tag_q[set][w] == tag);
	end

	assign hit = |hit_vec;
	assign victim = lru_q[set];
	assign way = hit ? hit_vec[1] : victim;

	assign lookup_o.hit = hit;
	assign lookup_o.way = way;
	assign lookup_o.victim_dirty = valid_q[set][victim] && dirty_q[set][victim];
	assign lookup_o.victim_tag = tag_q[set][victim];

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q <= '0;
		end
		else
		begin
			// Accessed way becomes MRU, the other one is next out
			if (access_i)
				lru_q[set] <= ~way;
			if (store_i)
				dirty_q[set][way] <= 1'b1;
			if (fill_i)
			begin
				valid_q[set][way] <= 1'b1;
				dirty_q[set][way] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (fill_i)
			tag_q[set][way] <= tag;
	end

	// A refill must never duplicate a tag already present in the set
	a_single_hit: assert property (@(posedge clk) disable iff (rst_i)
		!$isunknown(line_addr_i) |-> $onehot0(hit_vec))
		else $error("line present in both ways");

endmodule

/* design/l2_cache_pkg.sv */
/* Geometry, opcodes and bus types shared by every level-2 cache block.
   Modules import it with a wildcard inside their body. */
package l2_cache_pkg;

	// Line and memory word geometry
	localparam int WORD_BITS = 32;
	localparam int LINE_WORDS = 4;
	localparam int LINE_BITS = WORD_BITS * LINE_WORDS;
	localparam int LINE_BYTES = LINE_BITS / 8;

	// Set-associative layout
	localparam int NUM_SETS = 8;
	localparam int SET_BITS = 3;
	localparam int NUM_WAYS = 2;

	// Byte address minus the 4 offset bits
	localparam int LINE_ADDR_BITS = 28;
	localparam int TAG_BITS = LINE_ADDR_BITS - SET_BITS;

	// One beat per word, so a burst is LINE_WORDS beats
	localparam int BEAT_BITS = 2;

	typedef enum logic
	{
		OP_LOAD,
		OP_STORE
	} op_e;

	// Word 0 sits in the low bits and at the lowest address
	typedef union packed
	{
		logic [LINE_BITS-1:0] flat;
		logic [LINE_WORDS-1:0][WORD_BITS-1:0] words;
	} line_u;

	typedef struct packed
	{
		op_e op;
		logic [LINE_ADDR_BITS-1:0] line_addr;
		logic [LINE_BYTES-1:0] mask;
		line_u data;
	} cache_req_t;

	typedef struct packed
	{
		op_e op;
		line_u data;
	} cache_resp_t;

	// Tag check result, way is the hit way or else the LRU victim
	typedef struct packed
	{
		logic hit;
		logic way;
		logic victim_dirty;
		logic [TAG_BITS-1:0] victim_tag;
	} lookup_t;

endpackage
